// File: hdl/rv_mem_pkg.sv
////////////////////////////////////////
// Shared widths and RV32I encodings for the data-memory side
// RAM depth must stay a power of two, DMEM_AW is its log2
////////////////////////////////////////

package rv_mem_pkg;

	// Datapath
	localparam int XLEN   = 32;       // Register and RAM word width
	localparam int ADDR_W = 32;       // Byte address width from execute

	// Data RAM geometry
	localparam int DMEM_WORDS = 256;  // Depth in words
	localparam int DMEM_AW    = 8;    // Word index bits, log2 of DMEM_WORDS

	// Opcodes seen by the memory stage
	// Only LOAD and STORE touch the RAM, the rest pass i_result through
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_ALU   = 7'b0110011;  // Register-register ALU
	localparam logic [6:0] OP_JAL   = 7'b1101111;  // Link PC arrives in i_result

	// func3 access width for loads and stores
	localparam logic [2:0] F3_B  = 3'd0;  // Byte, sign extended
	localparam logic [2:0] F3_H  = 3'd1;  // Halfword, sign extended
	localparam logic [2:0] F3_W  = 3'd2;  // Full word
	localparam logic [2:0] F3_BU = 3'd4;  // Byte, zero extended
	localparam logic [2:0] F3_HU = 3'd5;  // Halfword, zero extended

	// Stores only use B, H and W
	// BU and HU are load-only codes

endpackage

// File: hdl/data_ram.sv
////////////////////////////////////////
// Combinational read, byte-lane writes on the rising edge
// Contents are undefined after power-up
////////////////////////////////////////

`timescale 1ns/1ps

module data_ram import rv_mem_pkg::*; (
	input  logic               clk,
	input  logic               i_we,
	input  logic [3:0]         i_be,     // One bit per byte lane
	input  logic [DMEM_AW-1:0] i_idx,    // Word index
	input  logic [XLEN-1:0]    i_wdata,
	output logic [XLEN-1:0]    o_rdata
);

	logic [XLEN-1:0] mem [DMEM_WORDS];

	// Lane b covers bits 8b+7 down to 8b
	always_ff @(posedge clk) begin
		if (i_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_be[b])
					mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
			end
		end
	end

	// Write at an edge is visible to a read in the next cycle
	assign o_rdata = mem[i_idx];

endmodule

// File: hdl/dmem_arbiter.sv
////////////////////////////////////////
// Host strobe always wins, a strobe every cycle starves the pipeline
// Host read data follows one cycle after the strobe
////////////////////////////////////////

`timescale 1ns/1ps

module dmem_arbiter import rv_mem_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	// Host port, whole words only
	input  logic               i_host_stb,
	input  logic               i_host_we,
	input  logic [DMEM_AW-1:0] i_host_addr,   // Word index
	input  logic [XLEN-1:0]    i_host_wdata,
	output logic [XLEN-1:0]    o_host_rdata,
	output logic               o_host_rvld,
	// Memory stage port
	input  logic               i_req,
	input  logic               i_wr_en,
	input  logic [3:0]         i_sel,
	input  logic [ADDR_W-3:0]  i_addr,        // Word address, upper bits ignored
	input  logic [XLEN-1:0]    i_wdata,
	output logic               o_d_valid,
	output logic [XLEN-1:0]    o_rdata,
	// RAM port
	input  logic [XLEN-1:0]    i_ram_rdata,
	output logic               o_ram_we,
	output logic [3:0]         o_ram_be,
	output logic [DMEM_AW-1:0] o_ram_idx,
	output logic [XLEN-1:0]    o_ram_wdata
);

	logic host_gnt;
	logic host_rd;   // Host read this cycle

	assign host_gnt  = i_host_stb;
	assign host_rd   = host_gnt & ~i_host_we;
	assign o_d_valid = i_req & ~host_gnt;  // Stage only when the host is idle

	// Winner onto the RAM port
	assign o_ram_we    = host_gnt ? i_host_we : (o_d_valid & i_wr_en);
	assign o_ram_be    = host_gnt ? 4'b1111 : i_sel;
	assign o_ram_idx   = host_gnt ? i_host_addr : i_addr[DMEM_AW-1:0];
	assign o_ram_wdata = host_gnt ? i_host_wdata : i_wdata;

	// Stage sees the raw word, it is only sampled on o_d_valid
	assign o_rdata = i_ram_rdata;

	// Host read valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_host_rvld <= 1'b0;
		else
			o_host_rvld <= host_rd;
	end

	// Host read word, held until the next host read
	always_ff @(posedge clk) begin
		if (host_rd)
			o_host_rdata <= i_ram_rdata;
	end

endmodule

// File: hdl/mem_stage.sv
////////////////////////////////////////
// Misaligned accesses are not trapped
// Lanes shifted off the word are lost
// Execute must hold all fields while o_stall is high
////////////////////////////////////////

`timescale 1ns/1ps

module mem_stage import rv_mem_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	// Execute side
	input  logic [XLEN-1:0]   i_result,      // ALU result, address or link PC
	input  logic [XLEN-1:0]   i_data_store,  // rs2 for stores
	input  logic [2:0]        i_func3,
	input  logic [4:0]        i_rd,
	input  logic [6:0]        i_opcode,
	input  logic              i_ex_valid,
	output logic              o_stall,
	// Write-back side
	output logic [4:0]        o_wb_rd,
	output logic [6:0]        o_opcode,
	output logic [XLEN-1:0]   o_wb_data,
	output logic              o_mem_vld,
	// Memory request toward the arbiter
	input  logic [XLEN-1:0]   i_rdata,       // Raw word in the grant cycle
	input  logic              i_d_valid,     // Combinational grant
	output logic              o_req,
	output logic              o_wr_en,
	output logic [3:0]        o_sel,         // Lanes after address shift
	output logic [ADDR_W-3:0] o_addr,        // Word address
	output logic [XLEN-1:0]   o_wdata        // Store data in its lanes
);

	logic            is_load;
	logic            is_store;
	logic            is_mem;
	logic            done;      // Instruction leaves the stage this cycle
	logic [1:0]      byte_off;
	logic [3:0]      sel_base;  // Lanes before shift
	logic [XLEN-1:0] ld_shift;
	logic [XLEN-1:0] ld_data;
	logic [XLEN-1:0] wb_data;

	assign is_load  = (i_opcode == OP_LOAD);
	assign is_store = (i_opcode == OP_STORE);
	assign is_mem   = is_load | is_store;
	assign byte_off = i_result[1:0];

	// Request goes out whenever a memory op is presented
	assign o_req   = i_ex_valid & is_mem;
	assign o_wr_en = is_store;
	assign o_addr  = i_result[ADDR_W-1:2];

	// Lost arbitration holds the instruction in execute
	assign o_stall = o_req & ~i_d_valid;

	// Non-memory ops never wait
	assign done = i_ex_valid & (~is_mem | i_d_valid);

	// Access width to lane mask
	always_comb begin
		case (i_func3)
			F3_B, F3_BU: sel_base = 4'b0001;
			F3_H, F3_HU: sel_base = 4'b0011;
			default:     sel_base = 4'b1111;  // Word and unused codes
		endcase
	end

	assign o_sel   = sel_base << byte_off;
	assign o_wdata = i_data_store << {byte_off, 3'b000};  // Byte offset to bit offset

	// Bring the addressed lanes down to bit 0
	assign ld_shift = i_rdata >> {byte_off, 3'b000};

	// Sign or zero extension by func3
	always_comb begin
		case (i_func3)
			F3_B:    ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
			F3_H:    ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
			F3_BU:   ld_data = {24'd0, ld_shift[7:0]};
			F3_HU:   ld_data = {16'd0, ld_shift[15:0]};
			default: ld_data = ld_shift;  // Word and reserved codes read the word
		endcase
	end

	// Loads return memory data and every other op returns i_result
	assign wb_data = is_load ? ld_data : i_result;

	// Valid pulses once per completed instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mem_vld <= 1'b0;
			o_wb_rd   <= '0;
			o_opcode  <= '0;
			o_wb_data <= '0;
		end else begin
			o_mem_vld <= done;
			if (done) begin
				o_wb_rd   <= i_rd;
				o_opcode  <= i_opcode;
				o_wb_data <= wb_data;
			end
		end
	end

endmodule

// File: hdl/lsu_top.sv
////////////////////////////////////////
// Memory stage, arbiter and data RAM
// Host port has priority over the pipeline
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top import rv_mem_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	// Execute side
	input  logic [XLEN-1:0]    i_result,
	input  logic [XLEN-1:0]    i_data_store,
	input  logic [2:0]         i_func3,
	input  logic [4:0]         i_rd,
	input  logic [6:0]         i_opcode,
	input  logic               i_ex_valid,
	output logic               o_stall,
	// Write-back side
	output logic [4:0]         o_wb_rd,
	output logic [6:0]         o_opcode,
	output logic [XLEN-1:0]    o_wb_data,
	output logic               o_mem_vld,
	// Host port
	input  logic               i_host_stb,
	input  logic               i_host_we,
	input  logic [DMEM_AW-1:0] i_host_addr,
	input  logic [XLEN-1:0]    i_host_wdata,
	output logic [XLEN-1:0]    o_host_rdata,
	output logic               o_host_rvld
);

	// Stage to arbiter
	logic              req;
	logic              wr_en;
	logic [3:0]        sel;
	logic [ADDR_W-3:0] addr;
	logic [XLEN-1:0]   wdata;
	logic              d_valid;
	logic [XLEN-1:0]   rdata;

	// Arbiter to RAM
	logic               ram_we;
	logic [3:0]         ram_be;
	logic [DMEM_AW-1:0] ram_idx;
	logic [XLEN-1:0]    ram_wdata;
	logic [XLEN-1:0]    ram_rdata;

	mem_stage u_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_result     (i_result),
		.i_data_store (i_data_store),
		.i_func3      (i_func3),
		.i_rd         (i_rd),
		.i_opcode     (i_opcode),
		.i_ex_valid   (i_ex_valid),
		.o_stall      (o_stall),
		.o_wb_rd      (o_wb_rd),
		.o_opcode     (o_opcode),
		.o_wb_data    (o_wb_data),
		.o_mem_vld    (o_mem_vld),
		.i_rdata      (rdata),
		.i_d_valid    (d_valid),
		.o_req        (req),
		.o_wr_en      (wr_en),
		.o_sel        (sel),
		.o_addr       (addr),
		.o_wdata      (wdata)
	);

	dmem_arbiter u_dmem_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_host_stb   (i_host_stb),
		.i_host_we    (i_host_we),
		.i_host_addr  (i_host_addr),
		.i_host_wdata (i_host_wdata),
		.o_host_rdata (o_host_rdata),
		.o_host_rvld  (o_host_rvld),
		.i_req        (req),
		.i_wr_en      (wr_en),
		.i_sel        (sel),
		.i_addr       (addr),
		.i_wdata      (wdata),
		.o_d_valid    (d_valid),
		.o_rdata      (rdata),
		.i_ram_rdata  (ram_rdata),
		.o_ram_we     (ram_we),
		.o_ram_be     (ram_be),
		.o_ram_idx    (ram_idx),
		.o_ram_wdata  (ram_wdata)
	);

	data_ram u_data_ram (
		.clk     (clk),
		.i_we    (ram_we),
		.i_be    (ram_be),
		.i_idx   (ram_idx),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

endmodule

// File: dv/lsu_checker.sv
////////////////////////////////////////
// Expected values arrive through push_wb and push_host
// Samples DUT outputs on the rising edge, in order per queue
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_checker import rv_mem_pkg::*; (
	input logic            clk,
	input logic            rst_n,
	input logic            i_mem_vld,
	input logic [4:0]      i_wb_rd,
	input logic [6:0]      i_opcode,
	input logic [XLEN-1:0] i_wb_data,
	input logic            i_host_rvld,
	input logic [XLEN-1:0] i_host_rdata
);

	string test_name = "none";
	int    test_checks;    // Per test
	int    test_errs;
	int    err_cnt;        // Whole run
	int    check_cnt;
	int    test_cnt;
	int    bad_tests;
	int    wb_pushed;      // Write-back counting for the current test
	int    wb_seen;
	int    host_pushed;
	int    host_seen;

	logic [4:0]      rd_q[$];
	logic [6:0]      op_q[$];
	logic [XLEN-1:0] wb_q[$];
	logic [XLEN-1:0] host_q[$];

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errs   = 0;
		wb_pushed   = 0;
		wb_seen     = 0;
		host_pushed = 0;
		host_seen   = 0;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		check_cnt++;
		if (exp !== act) begin
			test_errs++;
			err_cnt++;
			$display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		test_errs++;
		err_cnt++;
		$display("ERROR %s: %s", test_name, msg);
	endtask

	task automatic push_wb(input logic [4:0] rd, input logic [6:0] op, input logic [XLEN-1:0] data);
		rd_q.push_back(rd);
		op_q.push_back(op);
		wb_q.push_back(data);
		wb_pushed++;
	endtask

	task automatic push_host(input logic [XLEN-1:0] data);
		host_q.push_back(data);
		host_pushed++;
	endtask

	function automatic int pending();
		return wb_q.size() + host_q.size();
	endfunction

	// Counts catch lost or doubled responses
	task automatic finish_test();
		if (wb_seen != wb_pushed)
			report_problem($sformatf("saw %0d write-backs, expected %0d", wb_seen, wb_pushed));
		if (host_seen != host_pushed)
			report_problem($sformatf("saw %0d host reads, expected %0d", host_seen, host_pushed));
		rd_q.delete();
		op_q.delete();
		wb_q.delete();
		host_q.delete();
		test_cnt++;
		if (test_errs != 0)
			bad_tests++;
		$display("test %-12s %0d checks, %0d errors, %s", test_name, test_checks, test_errs,
			(test_errs == 0) ? "ok" : "bad");
	endtask

	task automatic report_totals();
		$display("%0d tests, %0d bad, %0d checks, %0d errors",
			test_cnt, bad_tests, check_cnt, err_cnt);
	endtask

	// Registered outputs, pre-edge value read here
	always @(posedge clk) begin : compare
		logic [4:0]      exp_rd;
		logic [6:0]      exp_op;
		logic [XLEN-1:0] exp_data;
		if (rst_n && i_mem_vld) begin
			wb_seen++;
			if (wb_q.size() == 0) begin
				report_problem("write-back valid with nothing outstanding");
			end else begin
				exp_rd   = rd_q.pop_front();
				exp_op   = op_q.pop_front();
				exp_data = wb_q.pop_front();
				check_value("o_wb_data", exp_data, i_wb_data);
				check_value("o_wb_rd", 32'(exp_rd), 32'(i_wb_rd));
				check_value("o_opcode", 32'(exp_op), 32'(i_opcode));
			end
		end
		if (rst_n && i_host_rvld) begin
			host_seen++;
			if (host_q.size() == 0)
				report_problem("host read valid with no read strobed");
			else
				check_value("o_host_rdata", host_q.pop_front(), i_host_rdata);
		end
	end

endmodule

// File: dv/tb_lsu.sv
////////////////////////////////////////
// Inputs driven on the falling edge
// Loads only hit words with known contents
// Shadow memory applies a host op before a stage op of one cycle
////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu import rv_mem_pkg::*; ();

	localparam int HALF       = 50;   // 100 ns clock
	localparam int RST_CYCLES = 16;
	localparam int N_HOST     = 16;   // Host write then read pairs
	localparam int N_ST       = 16;   // Stores each read back by host
	localparam int N_LD       = 16;   // Preload words and loads
	localparam int N_PASS     = 8;    // ALU and JAL ops
	localparam int N_COL      = 12;   // Host and stage in one cycle
	localparam int TOTAL_OPS  = 2*N_HOST + 2*N_ST + 2*N_LD + N_PASS + 2*N_COL;
	localparam int WD_CYCLES  = RST_CYCLES + 2*TOTAL_OPS + 100;

	logic               clk = 1'b0;
	logic               rst_n;
	logic [XLEN-1:0]    i_result;
	logic [XLEN-1:0]    i_data_store;
	logic [2:0]         i_func3;
	logic [4:0]         i_rd;
	logic [6:0]         i_opcode;
	logic               i_ex_valid;
	logic               i_host_stb;
	logic               i_host_we;
	logic [DMEM_AW-1:0] i_host_addr;
	logic [XLEN-1:0]    i_host_wdata;
	logic               o_stall;
	logic [4:0]         o_wb_rd;
	logic [6:0]         o_opcode;
	logic [XLEN-1:0]    o_wb_data;
	logic               o_mem_vld;
	logic [XLEN-1:0]    o_host_rdata;
	logic               o_host_rvld;

	logic [31:0]        rng = 32'hd049_df73;
	logic [XLEN-1:0]    shadow [DMEM_WORDS];
	logic [DMEM_AW-1:0] known_q[$];   // Words with defined contents
	logic [2:0]         f3_list [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};

	always #HALF clk = ~clk;

	lsu_top i_dut (.*);

	lsu_checker u_chk (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_mem_vld    (o_mem_vld),
		.i_wb_rd      (o_wb_rd),
		.i_opcode     (o_opcode),
		.i_wb_data    (o_wb_data),
		.i_host_rvld  (o_host_rvld),
		.i_host_rdata (o_host_rdata)
	);

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// Expected load result with the lane picked by offset then extended
	function automatic logic [XLEN-1:0] load_ref(input logic [XLEN-1:0] word,
			input logic [1:0] off, input logic [2:0] f3);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[8*off +: 8];
		h = word[16*off[1] +: 16];
		case (f3)
			F3_B:    return {{24{b[7]}}, b};
			F3_BU:   return {24'd0, b};
			F3_H:    return {{16{h[15]}}, h};
			F3_HU:   return {16'd0, h};
			default: return word;
		endcase
	endfunction

	// Store byte merge into the old word
	function automatic logic [XLEN-1:0] store_merge(input logic [XLEN-1:0] old,
			input logic [XLEN-1:0] data, input logic [1:0] off, input logic [2:0] f3);
		logic [XLEN-1:0] w;
		w = old;
		case (f3)
			F3_B:    w[8*off +: 8] = data[7:0];
			F3_H:    w[16*off[1] +: 16] = data[15:0];
			default: w = data;
		endcase
		return w;
	endfunction

	function automatic logic [2:0] pick_f3(input logic for_load);
		logic [31:0] r;
		r = next_rand();
		return f3_list[r[23:16] % (for_load ? 5 : 3)];  // Stores use B, H, W
	endfunction

	// Byte address in a known word aligned to the width
	task automatic pick_addr(input logic [2:0] f3, output logic [XLEN-1:0] addr);
		logic [31:0]        r;
		logic [DMEM_AW-1:0] idx;
		logic [1:0]         off;
		r   = next_rand();
		idx = known_q[r[31:8] % known_q.size()];
		case (f3)
			F3_B, F3_BU: off = r[17:16];
			F3_H, F3_HU: off = {r[17], 1'b0};
			default:     off = 2'b00;
		endcase
		addr = {{(XLEN-DMEM_AW-2){1'b0}}, idx, off};
	endtask

	// Model first then drive one op pair and wait for the grant
	task automatic run_cycle(input logic stg_v, input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [XLEN-1:0] res, input logic [XLEN-1:0] sdata,
			input logic h_stb, input logic h_we, input logic [DMEM_AW-1:0] h_idx,
			input logic [XLEN-1:0] h_wdata);
		logic               mem_op;
		logic               rd_strobe;  // Host read still owed its valid
		logic [DMEM_AW-1:0] idx;
		mem_op    = stg_v && (op == OP_LOAD || op == OP_STORE);
		rd_strobe = h_stb && !h_we;
		idx       = res[DMEM_AW+1:2];
		if (h_stb && h_we) begin
			shadow[h_idx] = h_wdata;
			known_q.push_back(h_idx);
		end else if (h_stb) begin
			u_chk.push_host(shadow[h_idx]);
		end
		if (stg_v && op == OP_LOAD)
			u_chk.push_wb(rd, op, load_ref(shadow[idx], res[1:0], f3));
		else if (stg_v)
			u_chk.push_wb(rd, op, res);  // Stores and pass-through return i_result
		if (stg_v && op == OP_STORE)
			shadow[idx] = store_merge(shadow[idx], sdata, res[1:0], f3);
		i_ex_valid   = stg_v;
		i_opcode     = op;
		i_func3      = f3;
		i_rd         = rd;
		i_result     = res;
		i_data_store = sdata;
		i_host_stb   = h_stb;
		i_host_we    = h_we;
		i_host_addr  = h_idx;
		i_host_wdata = h_wdata;
		#10;
		u_chk.check_value("o_stall", 32'(mem_op && h_stb), 32'(o_stall));
		while (o_stall) begin  // Held until the host leaves
			@(negedge clk);
			u_chk.check_value("o_host_rvld", 32'(rd_strobe), 32'(o_host_rvld));
			rd_strobe  = 1'b0;
			i_host_stb = 1'b0;
			#10;
		end
		@(negedge clk);
		// One cycle after the grant edge
		u_chk.check_value("o_host_rvld", 32'(rd_strobe), 32'(o_host_rvld));
		u_chk.check_value("o_mem_vld", 32'(stg_v), 32'(o_mem_vld));
		i_ex_valid = 1'b0;
		i_host_stb = 1'b0;
	endtask

	// Drain outstanding responses then wait a short quiet window
	task automatic close_test();
		int waited;
		waited = 0;
		while (u_chk.pending() != 0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		repeat (2) @(negedge clk);
		u_chk.finish_test();
	endtask

	initial begin
		logic [31:0]        r;
		logic [2:0]         f3;
		logic [6:0]         op;
		logic [XLEN-1:0]    res;
		logic [DMEM_AW-1:0] h_idx;
		rst_n        = 1'b0;
		i_result     = '0;
		i_data_store = '0;
		i_func3      = '0;
		i_rd         = '0;
		i_opcode     = '0;
		i_ex_valid   = 1'b0;
		i_host_stb   = 1'b0;
		i_host_we    = 1'b0;
		i_host_addr  = '0;
		i_host_wdata = '0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		u_chk.start_test("reset_idle");
		repeat (4) begin
			#10;
			u_chk.check_value("o_mem_vld", 32'd0, 32'(o_mem_vld));
			u_chk.check_value("o_host_rvld", 32'd0, 32'(o_host_rvld));
			u_chk.check_value("o_stall", 32'd0, 32'(o_stall));
			u_chk.check_value("o_wb_data", 32'd0, o_wb_data);
			@(negedge clk);
		end
		close_test();

		u_chk.start_test("host_rw");
		for (int i = 0; i < N_HOST; i++) begin
			r = next_rand();
			run_cycle(1'b0, OP_ALU, F3_W, 5'd0, '0, '0, 1'b1, 1'b1, r[23:16], next_rand());
		end
		for (int i = 0; i < N_HOST; i++) begin
			r = next_rand();
			h_idx = known_q[r[31:8] % N_HOST];
			run_cycle(1'b0, OP_ALU, F3_W, 5'd0, '0, '0, 1'b1, 1'b0, h_idx, '0);
		end
		close_test();

		u_chk.start_test("pipe_store");
		for (int i = 0; i < N_ST; i++) begin
			r  = next_rand();
			f3 = pick_f3(1'b0);
			pick_addr(f3, res);
			run_cycle(1'b1, OP_STORE, f3, r[20:16], res, next_rand(), 1'b0, 1'b0, '0, '0);
			run_cycle(1'b0, OP_ALU, F3_W, 5'd0, '0, '0, 1'b1, 1'b0, res[DMEM_AW+1:2], '0);
		end
		close_test();

		u_chk.start_test("pipe_load");
		for (int i = 0; i < N_LD; i++) begin
			r = next_rand();
			run_cycle(1'b0, OP_ALU, F3_W, 5'd0, '0, '0, 1'b1, 1'b1, r[23:16], next_rand());
		end
		for (int i = 0; i < N_LD; i++) begin
			r  = next_rand();
			f3 = pick_f3(1'b1);
			pick_addr(f3, res);
			run_cycle(1'b1, OP_LOAD, f3, r[20:16], res, '0, 1'b0, 1'b0, '0, '0);
		end
		for (int i = 0; i < N_PASS; i++) begin
			r  = next_rand();
			op = r[21] ? OP_JAL : OP_ALU;  // Result passes through unchanged
			run_cycle(1'b1, op, r[24:22], r[20:16], next_rand(), '0, 1'b0, 1'b0, '0, '0);
		end
		close_test();

		u_chk.start_test("collision");
		for (int i = 0; i < N_COL; i++) begin
			r  = next_rand();
			op = r[20] ? OP_STORE : OP_LOAD;
			f3 = pick_f3(!r[20]);
			pick_addr(f3, res);
			// Host reads only known words but writes may open a new one
			h_idx = (r[22] || !r[21]) ? res[DMEM_AW+1:2] : r[31:24];
			run_cycle(1'b1, op, f3, r[16:12], res, next_rand(), 1'b1, r[21], h_idx, next_rand());
		end
		close_test();

		u_chk.report_totals();
		if (u_chk.err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Run length bound from the op count
	initial begin
		#(WD_CYCLES * 2 * HALF);
		$display("Timeout after %0d cycles, the DUT stopped answering", WD_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: compile.f
hdl/rv_mem_pkg.sv
hdl/data_ram.sv
hdl/dmem_arbiter.sv
hdl/mem_stage.sv
hdl/lsu_top.sv
dv/lsu_checker.sv
dv/tb_lsu.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
# Exit status is nonzero unless the log holds the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/sim_lsu

verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu \
	-f compile.f -Mdir obj_dir -o sim_lsu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi
